// File: hdl/gas_box_settings.svh
`ifndef GAS_BOX_SETTINGS_SVH
`define GAS_BOX_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////
// Frame geometry
//////////////////////////////////////////////////////////////////////

// Visible frame in pixels
`define SCREEN_W 640
`define SCREEN_H 480

// Box centre on screen
`define BOX_CX 320
`define BOX_CY 240

// RGB 3-3-2 pixel values
`define COLOR_BLACK 8'h00
`define COLOR_WHITE 8'hFF

//////////////////////////////////////////////////////////////////////
// Simulation
//////////////////////////////////////////////////////////////////////

// Depth of the particle store
`define MAX_PARTICLES 16

// LFSR value after reset, must not be zero
`define LFSR_SEED 13'h000F
// Shifts between two usable random values
`define LFSR_PERIOD 14

// Timesteps per hit window, one extra step closes it
`define HIT_WINDOW 100

`endif

// File: hdl/gas_box_pkg.sv
package gas_box_pkg;

	// Unsigned screen coordinate
	typedef logic [9:0] coord_t;
	// Per-step displacement, two's complement
	typedef logic signed [9:0] velocity_t;
	// y * SCREEN_W + x
	typedef logic [18:0] pixel_addr_t;
	typedef logic [7:0] pixel_color_t;
	// 0 to 16 particles
	typedef logic [4:0] particle_count_t;
	typedef logic [9:0] hit_count_t;
	typedef logic [12:0] rnd_t;
	// Wait length in clock cycles
	typedef logic [31:0] delay_t;

	// Run configuration, held stable from reset on
	typedef struct packed {
		coord_t box_width;
		particle_count_t particle_count;
		velocity_t speed;
		delay_t frame_delay;
	} sim_config_t;

	// One particle state
	typedef struct packed {
		coord_t x;
		coord_t y;
		velocity_t vx;
		velocity_t vy;
	} particle_t;

	// Frame buffer write, valid while we is high
	typedef struct packed {
		logic we;
		pixel_addr_t addr;
		pixel_color_t color;
	} pixel_write_t;

	// Sequencer phases
	typedef enum logic [3:0] {
		s_clear,
		s_box_top,
		s_box_bottom,
		s_box_left,
		s_box_right,
		s_init,
		s_erase,
		s_move_draw,
		s_wait
	} seq_state_e;

endpackage

// File: hdl/lfsr_source.sv
`timescale 1ns/1ps
`include "gas_box_settings.svh"

module lfsr_source (
	input logic clock,
	input logic reset,
	output gas_box_pkg::rnd_t rnd,
	output logic rnd_strobe
);

	localparam int CNT_W = $clog2(`LFSR_PERIOD);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`LFSR_PERIOD - 1);

	// Fibonacci register, shifts left every cycle
	gas_box_pkg::rnd_t shift_reg;
	// Position inside the period
	logic [CNT_W-1:0] shift_count;
	logic feedback;

	// Taps 12, 3, 2 and 0
	assign feedback = shift_reg[12] ^ shift_reg[3] ^ shift_reg[2] ^ shift_reg[0];

	always_ff @(posedge clock) begin
		if (reset) begin
			shift_reg <= `LFSR_SEED;
			shift_count <= '0;
		end else begin
			shift_reg <= {shift_reg[11:0], feedback};
			if (shift_count == CNT_LAST)
				shift_count <= '0;
			else
				shift_count <= shift_count + 1'b1;
		end
	end

	// Fresh value on the last count of each period
	assign rnd_strobe = (shift_count == CNT_LAST);
	assign rnd = shift_reg;

endmodule

// File: hdl/wall_bounce.sv
`timescale 1ns/1ps
`include "gas_box_settings.svh"

module wall_bounce (
	input gas_box_pkg::particle_t current,
	input gas_box_pkg::coord_t box_half,
	output gas_box_pkg::particle_t next,
	output logic hit
);

	// Result of one axis
	typedef struct packed {
		gas_box_pkg::coord_t pos;
		gas_box_pkg::velocity_t vel;
		logic flip;
	} axis_step_t;

	axis_step_t step_x;
	axis_step_t step_y;

	// Reflect off walls at centre +/- half, then keep strictly inside
	function automatic axis_step_t axis_step(
		input gas_box_pkg::coord_t pos,
		input gas_box_pkg::velocity_t vel,
		input gas_box_pkg::coord_t centre,
		input gas_box_pkg::coord_t half
	);
		logic signed [11:0] lo;
		logic signed [11:0] hi;
		logic signed [11:0] probe;
		logic signed [11:0] moved;
		axis_step_t result;
		// Wider signed math so nothing wraps near the screen edge
		lo = $signed({2'b00, centre}) - $signed({2'b00, half});
		hi = $signed({2'b00, centre}) + $signed({2'b00, half});
		probe = $signed({2'b00, pos}) + $signed({{2{vel[9]}}, vel});
		result.flip = (probe >= hi) || (probe <= lo);
		result.vel = result.flip ? -vel : vel;
		moved = $signed({2'b00, pos}) + $signed({{2{result.vel[9]}}, result.vel});
		// Clamp to the inside of the walls
		if (moved <= lo)
			moved = lo + 12'sd1;
		else if (moved >= hi)
			moved = hi - 12'sd1;
		result.pos = moved[9:0];
		return result;
	endfunction

	assign step_x = axis_step(current.x, current.vx, 10'(`BOX_CX), box_half);
	assign step_y = axis_step(current.y, current.vy, 10'(`BOX_CY), box_half);

	assign next.x = step_x.pos;
	assign next.y = step_y.pos;
	assign next.vx = step_x.vel;
	assign next.vy = step_y.vel;
	// Any reflected axis counts as one wall hit
	assign hit = step_x.flip | step_y.flip;

endmodule

// File: hdl/hit_tally.sv
`timescale 1ns/1ps
`include "gas_box_settings.svh"

module hit_tally (
	input logic clock,
	input logic reset,
	input logic hit_pulse,
	input logic step_done,
	output gas_box_pkg::hit_count_t hits_per_window
);

	localparam int STEP_W = $clog2(`HIT_WINDOW + 1);
	localparam logic [STEP_W-1:0] STEP_LAST = STEP_W'(`HIT_WINDOW);

	// Hits in the open window
	gas_box_pkg::hit_count_t running;
	gas_box_pkg::hit_count_t running_next;
	// Timesteps closed so far in this window
	logic [STEP_W-1:0] step_count;

	// A hit in this cycle still counts toward the open window
	assign running_next = running + gas_box_pkg::hit_count_t'(hit_pulse);

	always_ff @(posedge clock) begin
		if (reset) begin
			running <= '0;
			step_count <= '0;
			hits_per_window <= '0;
		end else if (step_done && step_count == STEP_LAST) begin
			// Window closes, publish and restart
			hits_per_window <= running_next;
			running <= '0;
			step_count <= '0;
		end else begin
			running <= running_next;
			if (step_done)
				step_count <= step_count + 1'b1;
		end
	end

endmodule

// File: hdl/gas_box_sequencer.sv
`timescale 1ns/1ps
`include "gas_box_settings.svh"

module gas_box_sequencer (
	input logic clock,
	input logic reset,
	input gas_box_pkg::sim_config_t cfg,
	input gas_box_pkg::rnd_t rnd,
	input logic rnd_strobe,
	output gas_box_pkg::pixel_write_t pixel,
	output logic hit_pulse,
	output logic step_done
);

	localparam int IDX_W = $clog2(`MAX_PARTICLES);
	localparam gas_box_pkg::pixel_addr_t LAST_ADDR =
		gas_box_pkg::pixel_addr_t'(`SCREEN_W * `SCREEN_H - 1);

	// Particle store
	gas_box_pkg::particle_t store [`MAX_PARTICLES];

	// Control
	gas_box_pkg::seq_state_e state;
	gas_box_pkg::seq_state_e edge_next;
	gas_box_pkg::pixel_addr_t clear_addr;
	gas_box_pkg::pixel_addr_t edge_addr;
	gas_box_pkg::coord_t edge_count;
	logic [IDX_W-1:0] idx;
	logic last_idx;
	// Init pass, 0 x, 1 y, 2 direction
	logic [1:0] init_phase;
	gas_box_pkg::delay_t wait_count;

	// Box geometry from the configured width
	gas_box_pkg::coord_t box_half;
	gas_box_pkg::coord_t box_lo_x;
	gas_box_pkg::coord_t box_hi_x;
	gas_box_pkg::coord_t box_lo_y;
	gas_box_pkg::coord_t box_hi_y;
	gas_box_pkg::coord_t init_mask;
	gas_box_pkg::coord_t rnd_offset;
	gas_box_pkg::velocity_t dir_vx;
	gas_box_pkg::velocity_t dir_vy;

	// Stepped particle at idx
	gas_box_pkg::particle_t bounced;
	logic bounce_hit;

	function automatic gas_box_pkg::pixel_addr_t pixel_at(
		input gas_box_pkg::coord_t x,
		input gas_box_pkg::coord_t y
	);
		return gas_box_pkg::pixel_addr_t'(y) * gas_box_pkg::pixel_addr_t'(`SCREEN_W)
			+ gas_box_pkg::pixel_addr_t'(x);
	endfunction

	function automatic gas_box_pkg::pixel_write_t px_write(
		input gas_box_pkg::pixel_addr_t addr,
		input gas_box_pkg::pixel_color_t color
	);
		return '{we: 1'b1, addr: addr, color: color};
	endfunction

	assign box_half = cfg.box_width >> 1;
	assign box_lo_x = gas_box_pkg::coord_t'(`BOX_CX) - box_half;
	assign box_hi_x = gas_box_pkg::coord_t'(`BOX_CX) + box_half;
	assign box_lo_y = gas_box_pkg::coord_t'(`BOX_CY) - box_half;
	assign box_hi_y = gas_box_pkg::coord_t'(`BOX_CY) + box_half;

	// Start offsets must stay inside the box
	always_comb begin
		if (cfg.box_width < 10'd70)
			init_mask = 10'd31;
		else if (cfg.box_width < 10'd135)
			init_mask = 10'd63;
		else if (cfg.box_width < 10'd265)
			init_mask = 10'd127;
		else
			init_mask = 10'd255;
	end
	assign rnd_offset = rnd[9:0] & init_mask;

	// Direction from the two low random bits
	always_comb begin
		case (rnd[1:0])
			2'd0: {dir_vx, dir_vy} = {-cfg.speed, 10'sd0};
			2'd1: {dir_vx, dir_vy} = {10'sd0, cfg.speed};
			2'd2: {dir_vx, dir_vy} = {cfg.speed, 10'sd0};
			default: {dir_vx, dir_vy} = {10'sd0, -cfg.speed};
		endcase
	end

	assign last_idx = (gas_box_pkg::particle_count_t'(idx) == cfg.particle_count - 5'd1);

	// Outline address and successor for each edge
	always_comb begin
		case (state)
			gas_box_pkg::s_box_top: begin
				edge_addr = pixel_at(box_lo_x + edge_count, box_lo_y);
				edge_next = gas_box_pkg::s_box_bottom;
			end
			gas_box_pkg::s_box_bottom: begin
				edge_addr = pixel_at(box_lo_x + edge_count, box_hi_y);
				edge_next = gas_box_pkg::s_box_left;
			end
			gas_box_pkg::s_box_left: begin
				edge_addr = pixel_at(box_lo_x, box_lo_y + edge_count);
				edge_next = gas_box_pkg::s_box_right;
			end
			default: begin
				edge_addr = pixel_at(box_hi_x, box_lo_y + edge_count);
				edge_next = gas_box_pkg::s_init;
			end
		endcase
	end

	wall_bounce i_wall_bounce (
		.current(store[idx]),
		.box_half(box_half),
		.next(bounced),
		.hit(bounce_hit)
	);

	//////////////////////////////////////////////////////////////////////
	// Particle store updates
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (state == gas_box_pkg::s_init && rnd_strobe) begin
			case (init_phase)
				2'd0: store[idx].x <= rnd_offset + box_lo_x;
				2'd1: store[idx].y <= rnd_offset + box_lo_y;
				default: begin
					store[idx].vx <= dir_vx;
					store[idx].vy <= dir_vy;
				end
			endcase
		end else if (state == gas_box_pkg::s_move_draw) begin
			store[idx] <= bounced;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Phase FSM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= gas_box_pkg::s_clear;
			clear_addr <= '0;
			edge_count <= '0;
			idx <= '0;
			init_phase <= '0;
			wait_count <= '0;
			pixel <= '0;
			hit_pulse <= 1'b0;
			step_done <= 1'b0;
		end else begin
			// Strobes drop unless a phase raises them
			pixel.we <= 1'b0;
			hit_pulse <= 1'b0;
			step_done <= 1'b0;
			case (state)
				gas_box_pkg::s_clear: begin
					pixel <= px_write(clear_addr, `COLOR_BLACK);
					clear_addr <= clear_addr + 1'b1;
					if (clear_addr == LAST_ADDR)
						state <= gas_box_pkg::s_box_top;
				end
				gas_box_pkg::s_box_top,
				gas_box_pkg::s_box_bottom,
				gas_box_pkg::s_box_left,
				gas_box_pkg::s_box_right: begin
					// One idle cycle closes each edge
					if (edge_count < cfg.box_width) begin
						pixel <= px_write(edge_addr, `COLOR_WHITE);
						edge_count <= edge_count + 1'b1;
					end else begin
						edge_count <= '0;
						state <= edge_next;
					end
				end
				gas_box_pkg::s_init: begin
					// One value per strobe, x pass then y then direction
					if (rnd_strobe) begin
						if (last_idx) begin
							idx <= '0;
							if (init_phase == 2'd2) begin
								init_phase <= '0;
								state <= gas_box_pkg::s_erase;
							end else
								init_phase <= init_phase + 2'd1;
						end else
							idx <= idx + 1'b1;
					end
				end
				gas_box_pkg::s_erase: begin
					pixel <= px_write(pixel_at(store[idx].x, store[idx].y), `COLOR_BLACK);
					if (last_idx) begin
						idx <= '0;
						state <= gas_box_pkg::s_move_draw;
					end else
						idx <= idx + 1'b1;
				end
				gas_box_pkg::s_move_draw: begin
					pixel <= px_write(pixel_at(bounced.x, bounced.y), `COLOR_WHITE);
					hit_pulse <= bounce_hit;
					if (last_idx) begin
						idx <= '0;
						wait_count <= '0;
						state <= gas_box_pkg::s_wait;
					end else
						idx <= idx + 1'b1;
				end
				gas_box_pkg::s_wait: begin
					// frame_delay + 2 cycles, last one flags the step
					if (wait_count == cfg.frame_delay + 32'd1) begin
						step_done <= 1'b1;
						state <= gas_box_pkg::s_erase;
					end else
						wait_count <= wait_count + 32'd1;
				end
				default: state <= gas_box_pkg::s_clear;
			endcase
		end
	end

endmodule

// File: hdl/gas_box_top.sv
`timescale 1ns/1ps

module gas_box_top (
	input logic clock,
	input logic reset,
	input gas_box_pkg::sim_config_t cfg,
	output gas_box_pkg::pixel_write_t pixel,
	output logic step_done,
	output gas_box_pkg::hit_count_t hits_per_window
);

	// Random source to sequencer
	gas_box_pkg::rnd_t rnd;
	logic rnd_strobe;
	// Wall hit strobe to the tally
	logic hit_pulse;

	lfsr_source i_lfsr_source (
		.clock(clock),
		.reset(reset),
		.rnd(rnd),
		.rnd_strobe(rnd_strobe)
	);

	gas_box_sequencer i_gas_box_sequencer (
		.clock(clock),
		.reset(reset),
		.cfg(cfg),
		.rnd(rnd),
		.rnd_strobe(rnd_strobe),
		.pixel(pixel),
		.hit_pulse(hit_pulse),
		.step_done(step_done)
	);

	// Step strobe also leaves the top
	hit_tally i_hit_tally (
		.clock(clock),
		.reset(reset),
		.hit_pulse(hit_pulse),
		.step_done(step_done),
		.hits_per_window(hits_per_window)
	);

endmodule

// File: bench/gas_box_tb.sv
`timescale 1ns/1ps
`include "gas_box_settings.svh"

module gas_box_tb;

	localparam int NUM_ROWS = 4;
	localparam int CLEAR_LEN = `SCREEN_W * `SCREEN_H;

	// One run of the simulator
	typedef struct packed {
		int width;
		int count;
		int speed;
		int delay;
		int steps;
		bit jitter;
	} row_t;

	logic clock;
	logic reset;
	gas_box_pkg::sim_config_t cfg;
	gas_box_pkg::pixel_write_t pixel;
	logic step_done;
	gas_box_pkg::hit_count_t hits_per_window;

	// Reference particle store
	int px [`MAX_PARTICLES];
	int py [`MAX_PARTICLES];
	int pvx [`MAX_PARTICLES];
	int pvy [`MAX_PARTICLES];

	int failures;
	longint watchdog_cycles;
	bit watchdog_armed;

	gas_box_top i_dut (
		.clock(clock),
		.reset(reset),
		.cfg(cfg),
		.pixel(pixel),
		.step_done(step_done),
		.hits_per_window(hits_per_window)
	);

	// 20 ns period
	initial clock = 1'b0;
	always #10 clock = ~clock;

	//////////////////////////////////////////////////////////////////////
	// Checks and helpers
	//////////////////////////////////////////////////////////////////////

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] expected);
		if (got !== expected) begin
			failures++;
			$display("ERROR at %0t: %s got %0d expected %0d", $time, name, got, expected);
			$display("Checks failed");
			$fatal(1);
		end
	endtask

	task automatic fail_now(input string what);
		$display("%s at %0t", what, $time);
		$display("Checks failed");
		$fatal(1);
	endtask

	function automatic int addr_of(input int x, input int y);
		return y * `SCREEN_W + x;
	endfunction

	// Taps 12, 3, 2, 0 shifted in at the bottom
	function automatic gas_box_pkg::rnd_t lfsr_shift(input gas_box_pkg::rnd_t r);
		return {r[11:0], r[12] ^ r[3] ^ r[2] ^ r[0]};
	endfunction

	function automatic longint cycle_bound(input row_t row);
		return longint'(CLEAR_LEN) + 4 * row.width + 4 + 42 * row.count + 14
			+ longint'(row.steps) * (2 * row.count + row.delay + 4);
	endfunction

	// Sampled at the falling edge
	task automatic expect_write(input string what, input int addr, input int color);
		@(negedge clock);
		while (!pixel.we)
			@(negedge clock);
		check_value({what, " addr"}, pixel.addr, addr);
		check_value({what, " color"}, pixel.color, color);
	endtask

	task automatic check_quiet();
		check_value("pixel.we", pixel.we, 0);
		check_value("step_done", step_done, 0);
		check_value("hits_per_window", hits_per_window, 0);
	endtask

	// Wait ends on step_done with no writes in between
	task automatic await_step(input int expected_wait);
		int cycles;
		cycles = 0;
		do begin
			@(negedge clock);
			cycles++;
			if (pixel.we)
				fail_now("Pixel write during the wait phase");
		end while (!step_done);
		check_value("wait cycles", cycles, expected_wait);
	endtask

	// Reflect off centre +/- half and clamp strictly inside the walls
	task automatic bounce_axis(inout int pos, inout int vel, input int centre,
		input int half, output bit flip);
		int probe;
		probe = pos + vel;
		flip = (probe >= centre + half) || (probe <= centre - half);
		if (flip)
			vel = -vel;
		pos = pos + vel;
		if (pos <= centre - half)
			pos = centre - half + 1;
		else if (pos >= centre + half)
			pos = centre + half - 1;
	endtask

	// Start positions from the strobes that follow clear and outline
	task automatic place_particles(input int width, input int count, input int speed);
		gas_box_pkg::rnd_t r;
		int half;
		int mask;
		int offset;
		int first_edge;
		int j;
		half = width / 2;
		mask = (width < 70) ? 31 : (width < 135) ? 63 : (width < 265) ? 127 : 255;
		// First strobe edge after init is entered
		first_edge = ((CLEAR_LEN + 4 * (width + 1)) / `LFSR_PERIOD + 1) * `LFSR_PERIOD;
		r = `LFSR_SEED;
		repeat (first_edge - 1)
			r = lfsr_shift(r);
		for (int k = 0; k < 3 * count; k++) begin
			offset = int'(r) & mask;
			if (k < count)
				px[k] = offset + `BOX_CX - half;
			else if (k < 2 * count)
				py[k - count] = offset + `BOX_CY - half;
			else begin
				j = k - 2 * count;
				pvx[j] = 0;
				pvy[j] = 0;
				case (r[1:0])
					2'd0: pvx[j] = -speed;
					2'd1: pvy[j] = speed;
					2'd2: pvx[j] = speed;
					default: pvy[j] = -speed;
				endcase
			end
			repeat (`LFSR_PERIOD)
				r = lfsr_shift(r);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// One table row
	//////////////////////////////////////////////////////////////////////

	task automatic run_row(input row_t row);
		int half;
		int running;
		int published;
		bit hit_x;
		bit hit_y;
		half = row.width / 2;
		@(posedge clock);
		#1;
		reset = 1'b1;
		cfg.box_width = gas_box_pkg::coord_t'(row.width);
		cfg.particle_count = gas_box_pkg::particle_count_t'(row.count);
		cfg.speed = gas_box_pkg::velocity_t'(row.speed);
		cfg.frame_delay = gas_box_pkg::delay_t'(row.delay);
		repeat (10) begin
			@(posedge clock);
			#1;
			check_quiet();
		end
		reset = 1'b0;
		// Still idle before the first clear write
		@(negedge clock);
		check_quiet();
		for (int a = 0; a < CLEAR_LEN; a++)
			expect_write("clear", a, `COLOR_BLACK);
		// Outline top, bottom, left, right
		for (int k = 0; k < row.width; k++)
			expect_write("box top", addr_of(`BOX_CX - half + k, `BOX_CY - half), `COLOR_WHITE);
		for (int k = 0; k < row.width; k++)
			expect_write("box bottom", addr_of(`BOX_CX - half + k, `BOX_CY + half), `COLOR_WHITE);
		for (int k = 0; k < row.width; k++)
			expect_write("box left", addr_of(`BOX_CX - half, `BOX_CY - half + k), `COLOR_WHITE);
		for (int k = 0; k < row.width; k++)
			expect_write("box right", addr_of(`BOX_CX + half, `BOX_CY - half + k), `COLOR_WHITE);
		place_particles(row.width, row.count, row.speed);
		running = 0;
		published = 0;
		for (int s = 0; s < row.steps; s++) begin
			for (int i = 0; i < row.count; i++)
				expect_write("erase", addr_of(px[i], py[i]), `COLOR_BLACK);
			for (int i = 0; i < row.count; i++) begin
				bounce_axis(px[i], pvx[i], `BOX_CX, half, hit_x);
				bounce_axis(py[i], pvy[i], `BOX_CY, half, hit_y);
				if (hit_x || hit_y)
					running++;
				expect_write("draw", addr_of(px[i], py[i]), `COLOR_WHITE);
			end
			await_step(row.delay + 2);
			// Published total lags one step behind the closing step
			check_value("hits_per_window", hits_per_window, published);
			if (s % (`HIT_WINDOW + 1) == `HIT_WINDOW) begin
				published = int'(gas_box_pkg::hit_count_t'(running));
				running = 0;
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main flow and watchdog
	//////////////////////////////////////////////////////////////////////

	initial begin
		row_t rows [NUM_ROWS];
		longint bound;
		reset = 1'b1;
		cfg = '0;
		failures = 0;
		watchdog_armed = 1'b0;
		void'($urandom(32'h1c));
		// width, count, speed, delay, steps, jitter
		rows[0] = '{60, 8, 3, 5, 12, 1'b1};
		rows[1] = '{120, 16, 5, 0, 205, 1'b0};
		rows[2] = '{300, 16, 7, 3, 30, 1'b1};
		rows[3] = '{200, 1, 2, 10, 20, 1'b0};
		for (int r = 0; r < NUM_ROWS; r++)
			if (rows[r].jitter)
				rows[r].delay = rows[r].delay + int'($urandom % 4);
		bound = 0;
		for (int r = 0; r < NUM_ROWS; r++)
			bound = bound + cycle_bound(rows[r]);
		watchdog_cycles = 2 * bound;
		watchdog_armed = 1'b1;
		for (int r = 0; r < NUM_ROWS; r++)
			run_row(rows[r]);
		if (failures == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

	initial begin
		wait (watchdog_armed);
		repeat (watchdog_cycles)
			@(posedge clock);
		$display("Timeout: the run did not finish within %0d cycles", watchdog_cycles);
		$display("Checks failed");
		$fatal(1);
	end

endmodule

// File: src.f
+incdir+hdl
hdl/gas_box_pkg.sv
hdl/lfsr_source.sv
hdl/wall_bounce.sv
hdl/hit_tally.sv
hdl/gas_box_sequencer.sv
hdl/gas_box_top.sv
bench/gas_box_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the gas box testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 -Wno-fatal --top-module gas_box_tb -f src.f

# The log decides pass or fail
./obj_dir/Vgas_box_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Checks failed" sim.log; then
	echo "Simulation failed"
	exit 1
fi
if ! grep -q "All checks passed" sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi
echo "Simulation passed"
